//--- Makefile
TOP = tb_txasync

compile:
	verilator --binary --timing -j 0 --top-module $(TOP) -f verilog.f -Mdir obj_dir -o sim

run: compile
	./obj_dir/sim

clean:
	rm -rf obj_dir

.PHONY: compile run clean

//--- src/csr_pkg.sv
// configuration register map for the sideband transport
// wishbone vector types, addresses and bit positions

`default_nettype none

package csr_pkg;

        typedef logic [3:0]  wb_addr_t;
        typedef logic [31:0] wb_data_t;
        typedef logic [15:0] frame_cnt_t;

        // word addresses
        localparam wb_addr_t ADDR_CTRL    = 4'd0;
        localparam wb_addr_t ADDR_RST_VAL = 4'd1;
        localparam wb_addr_t ADDR_STATUS  = 4'd2;

        // ctrl fields
        localparam int CTRL_ENABLE   = 0;
        localparam int CTRL_LOOPBACK = 1;

        // status fields, parity flag is write one to clear
        localparam int STATUS_PAR_ERR = 0;
        localparam int FRAME_CNT_LSB  = 16;

endpackage

`default_nettype wire

//--- src/sr_capture.sv
// transmit capture stage
// synchronizes status bits, selects loopback and appends even parity

`timescale 1ns/10ps
`default_nettype none

module sr_capture #(
        parameter int SSR_WIDTH = sr_pkg::SSR_WIDTH_DEFAULT
) (
        input  wire                     osc_clk,
        input  wire                     rst,
        input  wire [SSR_WIDTH-1:0]     status_in,
        input  wire                     loopback,
        input  wire [SSR_WIDTH-1:0]     ctl_fb,
        output logic [SSR_WIDTH:0]      cap_word
);

        logic [SSR_WIDTH-1:0] sync_meta;
        logic [SSR_WIDTH-1:0] sync_q;
        logic [SSR_WIDTH-1:0] cap_sel;

        // two-flop synchronizer, each bit settles on its own
        always_ff @(posedge osc_clk) begin
                if (rst) begin
                        sync_meta <= '0;
                        sync_q    <= '0;
                end else begin
                        sync_meta <= status_in;
                        sync_q    <= sync_meta;
                end
        end

        // loopback sends the received outputs back out
        assign cap_sel = loopback ? ctl_fb : sync_q;

        // parity in the top bit makes the whole word xor to zero
        always_ff @(posedge osc_clk) begin
                if (rst) begin
                        cap_word <= '0;
                end else begin
                        cap_word <= {^cap_sel, cap_sel};
                end
        end

endmodule

`default_nettype wire

//--- src/sr_csr.sv
// wishbone classic slave for transport control
// holds enable, loopback, output reset value, parity flag and frame count

`timescale 1ns/10ps
`default_nettype none

module sr_csr #(
        parameter int SSR_WIDTH = sr_pkg::SSR_WIDTH_DEFAULT
) (
        input  wire                     osc_clk,
        input  wire                     rst,
        input  wire                     wb_cyc,
        input  wire                     wb_stb,
        input  wire                     wb_we,
        input  csr_pkg::wb_addr_t       wb_adr,
        input  csr_pkg::wb_data_t       wb_dat_w,
        input  wire                     frame_good,
        input  wire                     frame_bad,
        output csr_pkg::wb_data_t       wb_dat_r,
        output logic                    wb_ack,
        output logic                    enable,
        output logic                    loopback,
        output logic [SSR_WIDTH-1:0]    rst_val
);

        logic                   wr_strobe;
        logic                   par_err;
        csr_pkg::frame_cnt_t    frame_cnt;

        // single-cycle write, qualified so a held stb does not write twice
        assign wr_strobe = wb_cyc & wb_stb & wb_we & ~wb_ack;

        always_ff @(posedge osc_clk) begin
                if (rst) begin
                        wb_ack    <= 1'b0;
                        enable    <= 1'b0;
                        loopback  <= 1'b0;
                        rst_val   <= '0;
                        par_err   <= 1'b0;
                        frame_cnt <= '0;
                end else begin
                        wb_ack <= wb_cyc & wb_stb & ~wb_ack;
                        if (wr_strobe && wb_adr == csr_pkg::ADDR_CTRL) begin
                                enable   <= wb_dat_w[csr_pkg::CTRL_ENABLE];
                                loopback <= wb_dat_w[csr_pkg::CTRL_LOOPBACK];
                        end
                        if (wr_strobe && wb_adr == csr_pkg::ADDR_RST_VAL) begin
                                rst_val <= wb_dat_w[SSR_WIDTH-1:0];
                        end
                        // a new error wins over a clear in the same cycle
                        if (frame_bad) begin
                                par_err <= 1'b1;
                        end else if (wr_strobe && wb_adr == csr_pkg::ADDR_STATUS &&
                                     wb_dat_w[csr_pkg::STATUS_PAR_ERR]) begin
                                par_err <= 1'b0;
                        end
                        // wraps at full scale
                        if (frame_good) begin
                                frame_cnt <= frame_cnt + 1'b1;
                        end
                end
        end

        // read mux, sampled by the master with ack
        always_comb begin
                wb_dat_r = '0;
                case (wb_adr)
                        csr_pkg::ADDR_CTRL: begin
                                wb_dat_r[csr_pkg::CTRL_ENABLE]   = enable;
                                wb_dat_r[csr_pkg::CTRL_LOOPBACK] = loopback;
                        end
                        csr_pkg::ADDR_RST_VAL: wb_dat_r[SSR_WIDTH-1:0] = rst_val;
                        csr_pkg::ADDR_STATUS: begin
                                wb_dat_r[csr_pkg::STATUS_PAR_ERR] = par_err;
                                wb_dat_r[csr_pkg::FRAME_CNT_LSB +: $bits(frame_cnt)] = frame_cnt;
                        end
                        default: wb_dat_r = '0;
                endcase
        end

endmodule

`default_nettype wire

//--- src/sr_deserializer.sv
// SSR receive shift register
// collects serial bits and checks even parity on each load strobe

`timescale 1ns/10ps
`default_nettype none

module sr_deserializer #(
        parameter int SSR_WIDTH = sr_pkg::SSR_WIDTH_DEFAULT
) (
        input  wire                     osc_clk,
        input  wire                     rst,
        input  wire                     ser_data,
        input  wire                     ser_load,
        output logic [SSR_WIDTH-1:0]    rx_word,
        output logic                    frame_good,
        output logic                    frame_bad
);

        logic [SSR_WIDTH:0]     shift_q;
        logic                   par_ok;

        // lsb arrives first, so new bits enter at the top
        always_ff @(posedge osc_clk) begin
                if (!ser_load) begin
                        shift_q <= {ser_data, shift_q[SSR_WIDTH:1]};
                end
        end

        // data and parity together xor to zero on a clean frame
        assign par_ok = ~^shift_q;

        always_ff @(posedge osc_clk) begin
                if (rst) begin
                        frame_good <= 1'b0;
                        frame_bad  <= 1'b0;
                end else begin
                        frame_good <= ser_load & par_ok;
                        frame_bad  <= ser_load & ~par_ok;
                end
        end

        // data word, only meaningful alongside frame_good
        always_ff @(posedge osc_clk) begin
                if (ser_load) begin
                        rx_word <= shift_q[SSR_WIDTH-1:0];
                end
        end

endmodule

`default_nettype wire

//--- src/sr_pkg.sv
// shift-register transport definitions
// frame width default and serializer states

`default_nettype none

package sr_pkg;

        // status bits carried per SSR frame, parity excluded
        localparam int SSR_WIDTH_DEFAULT = 16;

        // serializer sequence
        // idle for one cycle, shift data and parity, then strobe load
        typedef enum logic [1:0] {
                SER_IDLE  = 2'd0,
                SER_SHIFT = 2'd1,
                SER_LOAD  = 2'd2
        } ser_state_t;

endpackage

`default_nettype wire

//--- src/sr_serializer.sv
// SSR frame sequencer
// shifts the captured word out lsb first, then strobes load

`timescale 1ns/10ps
`default_nettype none

module sr_serializer #(
        parameter int SSR_WIDTH = sr_pkg::SSR_WIDTH_DEFAULT
) (
        input  wire                     osc_clk,
        input  wire                     rst,
        input  wire                     enable,
        input  wire [SSR_WIDTH:0]       cap_word,
        output logic                    ser_data,
        output logic                    ser_load
);

        localparam int CNT_W = $clog2(SSR_WIDTH + 1);
        localparam logic [CNT_W-1:0] LAST_BIT = CNT_W'(SSR_WIDTH);

        sr_pkg::ser_state_t     state;
        logic [CNT_W-1:0]       bit_cnt;
        logic [SSR_WIDTH:0]     shift_q;

        always_ff @(posedge osc_clk) begin
                if (rst) begin
                        state   <= sr_pkg::SER_IDLE;
                        bit_cnt <= '0;
                end else begin
                        case (state)
                                // enable only matters here, a running frame completes
                                sr_pkg::SER_IDLE: begin
                                        bit_cnt <= '0;
                                        if (enable) begin
                                                state <= sr_pkg::SER_SHIFT;
                                        end
                                end
                                sr_pkg::SER_SHIFT: begin
                                        bit_cnt <= bit_cnt + 1'b1;
                                        if (bit_cnt == LAST_BIT) begin
                                                state <= sr_pkg::SER_LOAD;
                                        end
                                end
                                default: state <= sr_pkg::SER_IDLE;
                        endcase
                end
        end

        // frame payload
        always_ff @(posedge osc_clk) begin
                if (state == sr_pkg::SER_IDLE) begin
                        shift_q <= cap_word;
                end else begin
                        shift_q <= shift_q >> 1;
                end
        end

        // line is held low outside the data bits
        assign ser_data = (state == sr_pkg::SER_SHIFT) ? shift_q[0] : 1'b0;
        assign ser_load = (state == sr_pkg::SER_LOAD);

endmodule

`default_nettype wire

//--- src/sr_update.sv
// receive update stage
// drives the control outputs from good frames or the reset value

`timescale 1ns/10ps
`default_nettype none

module sr_update #(
        parameter int SSR_WIDTH = sr_pkg::SSR_WIDTH_DEFAULT
) (
        input  wire                     osc_clk,
        input  wire                     rst,
        input  wire                     enable,
        input  wire [SSR_WIDTH-1:0]     rst_val,
        input  wire [SSR_WIDTH-1:0]     rx_word,
        input  wire                     frame_good,
        output logic [SSR_WIDTH-1:0]    ctl_out
);

        // while disabled the outputs track the programmed reset value,
        // so it is also what they hold until the first good frame
        always_ff @(posedge osc_clk) begin
                if (rst) begin
                        ctl_out <= '0;
                end else if (!enable) begin
                        ctl_out <= rst_val;
                end else if (frame_good) begin
                        ctl_out <= rx_word;
                end
        end

endmodule

`default_nettype wire

//--- src/txasync_top.sv
// die-to-die sideband transport, transmit side with loop-back receiver
// joins the register block, capture, serializer, deserializer and update

`timescale 1ns/10ps
`default_nettype none

module txasync_top #(
        parameter int SSR_WIDTH = sr_pkg::SSR_WIDTH_DEFAULT
) (
        input  wire                     osc_clk,
        input  wire                     rst,
        input  wire                     wb_cyc,
        input  wire                     wb_stb,
        input  wire                     wb_we,
        input  csr_pkg::wb_addr_t       wb_adr,
        input  csr_pkg::wb_data_t       wb_dat_w,
        output csr_pkg::wb_data_t       wb_dat_r,
        output wire                     wb_ack,
        input  wire [SSR_WIDTH-1:0]     status_in,
        output wire                     sr_data_out,
        output wire                     sr_load_out,
        input  wire                     sr_data_in,
        input  wire                     sr_load_in,
        output wire [SSR_WIDTH-1:0]     ctl_out
);

        wire                    enable;
        wire                    loopback;
        wire [SSR_WIDTH-1:0]    rst_val;
        wire [SSR_WIDTH:0]      cap_word;
        wire [SSR_WIDTH-1:0]    rx_word;
        wire                    frame_good;
        wire                    frame_bad;

        sr_csr #(.SSR_WIDTH(SSR_WIDTH)) i_csr (
                .osc_clk    (osc_clk),
                .rst        (rst),
                .wb_cyc     (wb_cyc),
                .wb_stb     (wb_stb),
                .wb_we      (wb_we),
                .wb_adr     (wb_adr),
                .wb_dat_w   (wb_dat_w),
                .frame_good (frame_good),
                .frame_bad  (frame_bad),
                .wb_dat_r   (wb_dat_r),
                .wb_ack     (wb_ack),
                .enable     (enable),
                .loopback   (loopback),
                .rst_val    (rst_val)
        );

        // transmit path
        sr_capture #(.SSR_WIDTH(SSR_WIDTH)) i_capture (
                .osc_clk   (osc_clk),
                .rst       (rst),
                .status_in (status_in),
                .loopback  (loopback),
                .ctl_fb    (ctl_out),
                .cap_word  (cap_word)
        );

        sr_serializer #(.SSR_WIDTH(SSR_WIDTH)) i_serializer (
                .osc_clk  (osc_clk),
                .rst      (rst),
                .enable   (enable),
                .cap_word (cap_word),
                .ser_data (sr_data_out),
                .ser_load (sr_load_out)
        );

        // receive path, fed from the external serial line
        sr_deserializer #(.SSR_WIDTH(SSR_WIDTH)) i_deserializer (
                .osc_clk    (osc_clk),
                .rst        (rst),
                .ser_data   (sr_data_in),
                .ser_load   (sr_load_in),
                .rx_word    (rx_word),
                .frame_good (frame_good),
                .frame_bad  (frame_bad)
        );

        sr_update #(.SSR_WIDTH(SSR_WIDTH)) i_update (
                .osc_clk    (osc_clk),
                .rst        (rst),
                .enable     (enable),
                .rst_val    (rst_val),
                .rx_word    (rx_word),
                .frame_good (frame_good),
                .ctl_out    (ctl_out)
        );

endmodule

`default_nettype wire

//--- verif/tb_txasync.sv
// testbench for the sideband transport top level
// closes the serial loop, drives status words and checks ctl_out and the register block

`timescale 1ns/10ps
`default_nettype none

module tb_txasync;

        localparam int SSR_WIDTH     = 16;
        localparam int WB_TIMEOUT    = 8;
        localparam int POLL_LIMIT    = 60;
        localparam int FRAME_TIMEOUT = 100;
        localparam int FLIP_BIT      = 5;

        logic                   osc_clk = 1'b0;
        logic                   rst;
        logic                   wb_cyc;
        logic                   wb_stb;
        logic                   wb_we;
        csr_pkg::wb_addr_t      wb_adr;
        csr_pkg::wb_data_t      wb_dat_w;
        csr_pkg::wb_data_t      wb_dat_r;
        wire                    wb_ack;
        logic [SSR_WIDTH-1:0]   status_in;
        wire                    sr_data_out;
        wire                    sr_load_out;
        logic                   sr_data_in;
        logic                   sr_load_in;
        wire [SSR_WIDTH-1:0]    ctl_out;

        // reference model state owned by the stimulus process
        logic                   m_enable;
        logic                   m_loopback;
        logic [SSR_WIDTH-1:0]   m_rst_val;
        logic [SSR_WIDTH-1:0]   m_status;
        logic [SSR_WIDTH-1:0]   last_good;
        logic                   ctl_settled;
        logic [15:0]            lfsr_state;
        int                     corrupt_seq;

        // frame tallies owned by the serial loop
        csr_pkg::frame_cnt_t    good_frames;
        int                     bad_frames;
        logic [SSR_WIDTH:0]     line_frame;

        txasync_top #(.SSR_WIDTH(SSR_WIDTH)) i_dut (
                .osc_clk     (osc_clk),
                .rst         (rst),
                .wb_cyc      (wb_cyc),
                .wb_stb      (wb_stb),
                .wb_we       (wb_we),
                .wb_adr      (wb_adr),
                .wb_dat_w    (wb_dat_w),
                .wb_dat_r    (wb_dat_r),
                .wb_ack      (wb_ack),
                .status_in   (status_in),
                .sr_data_out (sr_data_out),
                .sr_load_out (sr_load_out),
                .sr_data_in  (sr_data_in),
                .sr_load_in  (sr_load_in),
                .ctl_out     (ctl_out)
        );

        always #10 osc_clk = ~osc_clk;

        function automatic logic [15:0] lfsr_next(input logic [15:0] s);
                return s[0] ? ((s >> 1) ^ 16'hB400) : (s >> 1);
        endfunction

        // expected ctl_out from the transport rules
        function automatic logic [SSR_WIDTH-1:0] expect_ctl(input logic en, input logic lb,
                        input logic [SSR_WIDTH-1:0] rv, input logic [SSR_WIDTH-1:0] st,
                        input logic [SSR_WIDTH-1:0] last);
                if (!en) begin
                        return rv;
                end
                if (lb) begin
                        return last;
                end
                return st;
        endfunction

        // line frame of a data word with the even parity bit on top
        function automatic logic [SSR_WIDTH:0] expect_frame(input logic [SSR_WIDTH-1:0] d);
                int ones;
                int b;
                ones = 0;
                for (b = 0; b < SSR_WIDTH; b++) begin
                        ones += d[b];
                end
                return {ones[0], d};
        endfunction

        task automatic fail_run(input string msg);
                $display("%s", msg);
                $display("TEST FAILED");
                $fatal(1, "simulation stopped on first error");
        endtask

        task automatic check_ctl(input logic [SSR_WIDTH-1:0] act,
                        input logic [SSR_WIDTH-1:0] exp, input string name);
                if (act !== exp) begin
                        fail_run($sformatf("** Error at %0t: %s expected %h, got %h",
                                           $time, name, exp, act));
                end
        endtask

        task automatic check_frame(input logic [SSR_WIDTH:0] act,
                        input logic [SSR_WIDTH:0] exp, input string name);
                if (act !== exp) begin
                        fail_run($sformatf("** Error at %0t: %s expected %h, got %h",
                                           $time, name, exp, act));
                end
        endtask

        task automatic check_data(input csr_pkg::wb_data_t act, input csr_pkg::wb_data_t exp,
                        input string name);
                if (act !== exp) begin
                        fail_run($sformatf("** Error at %0t: %s expected %h, got %h",
                                           $time, name, exp, act));
                end
        endtask

        task automatic check_cnt(input csr_pkg::frame_cnt_t act, input csr_pkg::frame_cnt_t exp,
                        input string name);
                if (act !== exp) begin
                        fail_run($sformatf("** Error at %0t: %s expected %0d, got %0d",
                                           $time, name, exp, act));
                end
        endtask

        // classic cycle with ack seen on the falling edge after it rises
        task automatic wb_access(input logic we, input csr_pkg::wb_addr_t adr,
                        input csr_pkg::wb_data_t wdat, output csr_pkg::wb_data_t rdat);
                int n;
                wb_cyc   = 1'b1;
                wb_stb   = 1'b1;
                wb_we    = we;
                wb_adr   = adr;
                wb_dat_w = wdat;
                for (n = 0; n < WB_TIMEOUT && !wb_ack; n++) begin
                        @(negedge osc_clk);
                end
                if (!wb_ack) begin
                        fail_run("wishbone access got no ack");
                end
                rdat   = wb_dat_r;
                wb_cyc = 1'b0;
                wb_stb = 1'b0;
                wb_we  = 1'b0;
                @(negedge osc_clk);
        endtask

        task automatic wb_write(input csr_pkg::wb_addr_t adr, input csr_pkg::wb_data_t data);
                csr_pkg::wb_data_t unused;
                wb_access(1'b1, adr, data, unused);
        endtask

        task automatic wb_read(input csr_pkg::wb_addr_t adr, output csr_pkg::wb_data_t data);
                wb_access(1'b0, adr, '0, data);
        endtask

        // one lfsr step per status bit
        task automatic next_word(output logic [SSR_WIDTH-1:0] v);
                int b;
                for (b = 0; b < SSR_WIDTH; b++) begin
                        lfsr_state = lfsr_next(lfsr_state);
                        v[b] = lfsr_state[0];
                end
        endtask

        // new status word held past the synchronizer and parity register
        task automatic apply_status();
                logic [SSR_WIDTH-1:0] v;
                next_word(v);
                status_in = v;
                m_status  = v;
                repeat (4) @(negedge osc_clk);
        endtask

        task automatic wait_ctl(input logic [SSR_WIDTH-1:0] exp);
                int n;
                for (n = 0; n < WB_TIMEOUT && ctl_out !== exp; n++) begin
                        @(negedge osc_clk);
                end
                check_ctl(ctl_out, exp, "ctl_out");
        endtask

        task automatic wait_two_frames();
                csr_pkg::wb_data_t rd;
                csr_pkg::frame_cnt_t c0;
                csr_pkg::frame_cnt_t c;
                int n;
                wb_read(csr_pkg::ADDR_STATUS, rd);
                c0 = rd[csr_pkg::FRAME_CNT_LSB +: 16];
                c  = c0;
                for (n = 0; n < POLL_LIMIT && csr_pkg::frame_cnt_t'(c - c0) < 16'd2; n++) begin
                        wb_read(csr_pkg::ADDR_STATUS, rd);
                        c = rd[csr_pkg::FRAME_CNT_LSB +: 16];
                end
                if (csr_pkg::frame_cnt_t'(c - c0) < 16'd2) begin
                        fail_run("frame counter did not advance by two");
                end
        endtask

        // counter read in the quiet gap after a load strobe
        task automatic take_snapshot(output csr_pkg::frame_cnt_t cnt,
                        output csr_pkg::frame_cnt_t good);
                csr_pkg::wb_data_t rd;
                int n;
                for (n = 0; n < FRAME_TIMEOUT && !sr_load_out; n++) begin
                        @(negedge osc_clk);
                end
                if (!sr_load_out) begin
                        fail_run("no load strobe seen on the serial line");
                end
                repeat (3) @(negedge osc_clk);
                wb_read(csr_pkg::ADDR_STATUS, rd);
                cnt  = rd[csr_pkg::FRAME_CNT_LSB +: 16];
                good = good_frames;
        endtask

        // serial loop with data bit k at the (k+2)th cycle after SER_LOAD
        initial begin : serial_loop
                int   pos;
                int   corrupt_taken;
                logic corrupt_frame;
                logic flip;
                logic [SSR_WIDTH:0] frame_bits;
                sr_data_in    = 1'b0;
                sr_load_in    = 1'b0;
                good_frames   = '0;
                bad_frames    = 0;
                line_frame    = '0;
                frame_bits    = '0;
                pos           = 0;
                corrupt_taken = 0;
                corrupt_frame = 1'b0;
                forever begin
                        @(negedge osc_clk);
                        flip = 1'b0;
                        if (sr_load_out) begin
                                if (sr_data_out !== 1'b0) begin
                                        fail_run($sformatf(
                                                "** Error at %0t: sr_data_out expected 0, got %b",
                                                $time, sr_data_out));
                                end
                                if (corrupt_frame) begin
                                        bad_frames++;
                                end else begin
                                        good_frames = good_frames + 16'd1;
                                end
                                corrupt_frame = (corrupt_seq != corrupt_taken);
                                corrupt_taken = corrupt_seq;
                                line_frame    = frame_bits;
                                pos = 0;
                        end else begin
                                pos++;
                                if (pos >= 2 && pos <= SSR_WIDTH + 2) begin
                                        frame_bits[pos - 2] = sr_data_out;
                                end
                                flip = corrupt_frame && (pos == FLIP_BIT + 2);
                        end
                        sr_data_in = sr_data_out ^ flip;
                        sr_load_in = sr_load_out;
                end
        end

        // continuous compare while the model says ctl_out has settled
        always @(negedge osc_clk) begin
                if (ctl_settled) begin
                        check_ctl(ctl_out, expect_ctl(m_enable, m_loopback, m_rst_val,
                                                      m_status, last_good), "ctl_out");
                end
        end

        initial begin : stimulus
                csr_pkg::wb_data_t   rd;
                csr_pkg::frame_cnt_t c0;
                csr_pkg::frame_cnt_t c1;
                csr_pkg::frame_cnt_t g0;
                csr_pkg::frame_cnt_t g1;
                logic [SSR_WIDTH-1:0] rv;
                int i;
                int b0;
                int n;
                rst         = 1'b1;
                wb_cyc      = 1'b0;
                wb_stb      = 1'b0;
                wb_we       = 1'b0;
                wb_adr      = '0;
                wb_dat_w    = '0;
                status_in   = '0;
                m_enable    = 1'b0;
                m_loopback  = 1'b0;
                m_rst_val   = '0;
                m_status    = '0;
                last_good   = '0;
                ctl_settled = 1'b0;
                corrupt_seq = 0;
                lfsr_state  = 16'd75;
                repeat (5) @(negedge osc_clk);
                rst         = 1'b0;
                ctl_settled = 1'b1;

                // reset values and then the programmed output reset value
                wb_read(csr_pkg::ADDR_CTRL, rd);
                check_data(rd, '0, "CTRL");
                wb_read(csr_pkg::ADDR_RST_VAL, rd);
                check_data(rd, '0, "RST_VAL");
                wb_read(csr_pkg::ADDR_STATUS, rd);
                check_data(rd, '0, "STATUS");
                next_word(rv);
                ctl_settled = 1'b0;
                m_rst_val   = rv;
                wb_write(csr_pkg::ADDR_RST_VAL, {16'd0, rv});
                wait_ctl(rv);
                ctl_settled = 1'b1;
                wb_read(csr_pkg::ADDR_RST_VAL, rd);
                check_data(rd, {16'd0, rv}, "RST_VAL");

                // tracking of held status words
                ctl_settled = 1'b0;
                m_enable    = 1'b1;
                wb_write(csr_pkg::ADDR_CTRL, 32'h1);
                for (i = 0; i < 20; i++) begin
                        ctl_settled = 1'b0;
                        apply_status();
                        wait_two_frames();
                        last_good   = m_status;
                        check_ctl(ctl_out, expect_ctl(m_enable, m_loopback, m_rst_val,
                                                      m_status, last_good), "ctl_out");
                        check_frame(line_frame, expect_frame(m_status), "sr_data_out frame");
                        ctl_settled = 1'b1;
                        @(negedge osc_clk);
                end

                // one corrupted frame is dropped and flagged
                take_snapshot(c0, g0);
                b0 = bad_frames;
                corrupt_seq++;
                for (n = 0; n < 3 * FRAME_TIMEOUT && bad_frames == b0; n++) begin
                        @(negedge osc_clk);
                end
                if (bad_frames == b0) begin
                        fail_run("corrupted frame was never sent");
                end
                repeat (3) @(negedge osc_clk);
                wb_read(csr_pkg::ADDR_STATUS, rd);
                check_data(rd & 32'h1, 32'h1, "STATUS.par_err");
                check_cnt(rd[csr_pkg::FRAME_CNT_LSB +: 16], c0 + (good_frames - g0),
                          "STATUS.frame_cnt");
                wb_write(csr_pkg::ADDR_STATUS, 32'h1);
                wb_read(csr_pkg::ADDR_STATUS, rd);
                check_data(rd & 32'h1, 32'h0, "STATUS.par_err");

                // loopback holds the last value whatever status_in does
                m_loopback = 1'b1;
                wb_write(csr_pkg::ADDR_CTRL, 32'h3);
                for (i = 0; i < 4; i++) begin
                        apply_status();
                        wait_two_frames();
                end

                // disable falls back to the reset value and enable resumes tracking
                ctl_settled = 1'b0;
                m_enable    = 1'b0;
                m_loopback  = 1'b0;
                wb_write(csr_pkg::ADDR_CTRL, 32'h0);
                wait_ctl(m_rst_val);
                ctl_settled = 1'b1;
                repeat (2 * (SSR_WIDTH + 3)) @(negedge osc_clk);
                ctl_settled = 1'b0;
                m_enable    = 1'b1;
                wb_write(csr_pkg::ADDR_CTRL, 32'h1);
                apply_status();
                wait_two_frames();
                last_good   = m_status;
                ctl_settled = 1'b1;

                // counter against good frames seen on the line
                take_snapshot(c0, g0);
                wait_two_frames();
                wait_two_frames();
                take_snapshot(c1, g1);
                check_cnt(c1 - c0, g1 - g0, "frame count delta");

                $display("TEST PASSED");
                $finish;
        end

endmodule

`default_nettype wire

//--- verilog.f
src/sr_pkg.sv
src/csr_pkg.sv
src/sr_csr.sv
src/sr_capture.sv
src/sr_serializer.sv
src/sr_deserializer.sv
src/sr_update.sv
src/txasync_top.sv
verif/tb_txasync.sv
